// File: compile.f
+incdir+hw
hw/memPkg.sv
hw/dataPort.sv
hw/fetchPort.sv
hw/memCtrl.sv
hw/byteRam.sv
hw/memSubsystem.sv
testbench/tbMemSubsystem.sv

// File: hw/byteRam.sv
`timescale 1ns/1ps
`include "mem_defs.svh"

module byteRam import memPkg::*; (
    input  logic    clk,
    input  ramAddrT ramAddr,
    input  logic    ramWe,
    input  byteT    ramWdata,
    output byteT    ramRdata
);

    localparam int RAM_SIZE = 1 << `RAM_ADDR_WIDTH;

    byteT mem [RAM_SIZE];

    // Starts cleared.
    initial begin
        for (int i = 0; i < RAM_SIZE; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (ramWe) begin
            mem[ramAddr] <= ramWdata;
        end
        ramRdata <= mem[ramAddr];
    end

endmodule

// File: hw/dataPort.sv
`timescale 1ns/1ps

module dataPort import memPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    rdy,

    input  logic    slbEn,
    input  logic    slbStore,
    input  addrT    slbAddr,
    input  dataT    slbData,
    input  lenT     slbLen,
    input  nickT    slbNick,
    output logic    slbFree,
    output logic    slbDone,
    output dataT    slbResult,
    output nickT    slbDoneNick,

    input  memWaitT memWait,
    input  logic    dataDone,
    input  dataT    dataRdata,
    output logic    dataReq,
    output logic    dataStore,
    output addrT    dataAddr,
    output dataT    dataWdata,
    output lenT     dataLen
);

    logic occupied;
    logic doneQ;
    nickT nick;

    assign slbFree = rdy && !occupied;
    assign dataReq = rdy && occupied && !memWait[1];

    // Pulse stays hidden while the core is stalled.
    assign slbDone = rdy && doneQ;

    always_ff @(posedge clk) begin
        if (rst) begin
            occupied <= 1'b0;
            doneQ    <= 1'b0;
        end else if (rdy) begin
            doneQ <= dataDone;
            if (dataDone) begin
                occupied <= 1'b0;
            end else if (slbEn && slbFree) begin
                occupied <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            if (slbEn && !occupied) begin
                dataStore <= slbStore;
                dataAddr  <= slbAddr;
                dataWdata <= slbData;
                dataLen   <= slbLen;
                nick      <= slbNick;
            end
            // Result leaves with the tag it came in with.
            if (dataDone) begin
                slbResult   <= dataRdata;
                slbDoneNick <= nick;
            end
        end
    end

endmodule

// File: hw/fetchPort.sv
`timescale 1ns/1ps
`include "mem_defs.svh"

module fetchPort import memPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    rdy,

    input  logic    fetchEn,
    input  addrT    fetchAddr,
    output logic    fetchBusy,
    output logic    fetchDone,
    output dataT    fetchInst,

    input  memWaitT memWait,
    input  logic    instDone,
    input  dataT    instRdata,
    output logic    instReq,
    output addrT    instAddr
);

    localparam int LINES     = 1 << `ICACHE_INDEX_WIDTH;
    localparam int TAG_WIDTH = `ADDR_WIDTH - `ICACHE_INDEX_WIDTH - 2;

    typedef logic [`ICACHE_INDEX_WIDTH-1:0] indexT;
    typedef logic [TAG_WIDTH-1:0] tagT;

    logic [LINES-1:0] lineValid;
    tagT              lineTag [LINES];
    dataT             lineWord [LINES];

    logic  missing;
    addrT  missAddr;
    logic  doneQ;
    logic  accept;
    logic  hit;
    indexT reqIdx;
    tagT   reqTag;
    indexT missIdx;
    tagT   missTag;

    // Word address bits pick the line.
    assign reqIdx  = fetchAddr[`ICACHE_INDEX_WIDTH+1:2];
    assign reqTag  = fetchAddr[`ADDR_WIDTH-1:`ICACHE_INDEX_WIDTH+2];
    assign missIdx = missAddr[`ICACHE_INDEX_WIDTH+1:2];
    assign missTag = missAddr[`ADDR_WIDTH-1:`ICACHE_INDEX_WIDTH+2];

    assign hit    = lineValid[reqIdx] && (lineTag[reqIdx] == reqTag);
    assign accept = rdy && fetchEn && !missing;

    assign fetchBusy = missing;
    assign fetchDone = rdy && doneQ;
    assign instReq   = rdy && missing && !memWait[0];
    assign instAddr  = missAddr;

    always_ff @(posedge clk) begin
        if (rst) begin
            lineValid <= '0;
            missing   <= 1'b0;
            doneQ     <= 1'b0;
        end else if (rdy) begin
            doneQ <= 1'b0;
            if (instDone) begin
                lineValid[missIdx] <= 1'b1;
                missing            <= 1'b0;
                doneQ              <= 1'b1;
            end else if (accept) begin
                if (hit) begin
                    doneQ <= 1'b1;
                end else begin
                    missing <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            if (instDone) begin
                // Refill word goes to the line and straight out.
                lineTag[missIdx]  <= missTag;
                lineWord[missIdx] <= instRdata;
                fetchInst         <= instRdata;
            end else if (accept) begin
                if (hit) begin
                    fetchInst <= lineWord[reqIdx];
                end else begin
                    missAddr <= {fetchAddr[`ADDR_WIDTH-1:2], 2'b00};
                end
            end
        end
    end

endmodule

// File: hw/memCtrl.sv
`timescale 1ns/1ps

module memCtrl import memPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    rdy,

    input  logic    dataReq,
    input  logic    dataStore,
    input  addrT    dataAddr,
    input  dataT    dataWdata,
    input  lenT     dataLen,
    output logic    dataDone,
    output dataT    dataRdata,

    input  logic    instReq,
    input  addrT    instAddr,
    output logic    instDone,
    output dataT    instRdata,

    output memWaitT memWait,

    output ramAddrT ramAddr,
    output logic    ramWe,
    output byteT    ramWdata,
    input  byteT    ramRdata
);

    ctrlStateT  state;
    logic       servedData;
    logic       isStore;
    ramAddrT    baseAddr;
    dataT       wdata;
    lenT        len;
    lenT        count;
    dataT       rdata;
    logic [1:0] loadIdx;
    logic       lastStep;
    logic       xfer;

    assign xfer = (state == DATA_XFER) || (state == FETCH_XFER);

    // Data outranks fetch, so a pending data request blocks the fetch side too.
    assign memWait[1] = (state != IDLE);
    assign memWait[0] = (state != IDLE) || dataReq;

    // Stalled cycles reread the previous address to hold ramRdata.
    assign ramAddr  = baseAddr + ramAddrT'(count) - ramAddrT'(!rdy);
    assign ramWe    = rdy && (state == DATA_XFER) && isStore;
    assign ramWdata = byteT'(wdata >> {count, 3'b000});

    // Byte returned now belongs to the previous address.
    assign loadIdx = count[1:0] - 2'd1;

    // A load needs one extra cycle to catch the last byte.
    assign lastStep = isStore ? (count == len - 1'b1) : (count == len);

    assign dataDone  = rdy && (state == DONE) && servedData;
    assign instDone  = rdy && (state == DONE) && !servedData;
    assign dataRdata = rdata;
    assign instRdata = rdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= IDLE;
            servedData <= 1'b0;
            isStore    <= 1'b0;
            count      <= '0;
        end else if (rdy) begin
            case (state)
                IDLE: begin
                    count <= '0;
                    if (dataReq) begin
                        state      <= DATA_XFER;
                        servedData <= 1'b1;
                        isStore    <= dataStore;
                    end else if (instReq) begin
                        state      <= FETCH_XFER;
                        servedData <= 1'b0;
                        isStore    <= 1'b0;
                    end
                end
                DATA_XFER, FETCH_XFER: begin
                    count <= count + 1'b1;
                    if (lastStep) begin
                        state <= DONE;
                    end
                end
                DONE: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            if (state == IDLE) begin
                if (dataReq) begin
                    baseAddr <= ramAddrT'(dataAddr);
                    wdata    <= dataWdata;
                    len      <= dataLen;
                end else begin
                    // Refills are always one word.
                    baseAddr <= ramAddrT'(instAddr);
                    len      <= lenT'(4);
                end
                rdata <= '0;
            end else if (xfer && !isStore && count != '0) begin
                rdata[{loadIdx, 3'b000} +: 8] <= ramRdata;
            end
        end
    end

endmodule

// File: hw/memPkg.sv
`include "mem_defs.svh"

package memPkg;

    typedef logic [`ADDR_WIDTH-1:0] addrT;
    typedef logic [`DATA_WIDTH-1:0] dataT;
    typedef logic [`BYTE_WIDTH-1:0] byteT;
    typedef logic [`LEN_WIDTH-1:0] lenT;
    typedef logic [`NICK_WIDTH-1:0] nickT;
    typedef logic [`RAM_ADDR_WIDTH-1:0] ramAddrT;

    // Bit 0 blocks fetch requests, bit 1 blocks data requests.
    typedef logic [`WAIT_WIDTH-1:0] memWaitT;

    // Memory controller sequencer.
    typedef enum logic [1:0] {
        IDLE,
        DATA_XFER,
        FETCH_XFER,
        DONE
    } ctrlStateT;

endpackage

// File: hw/memSubsystem.sv
`timescale 1ns/1ps

module memSubsystem import memPkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic rdy,

    input  logic slbEn,
    input  logic slbStore,
    input  addrT slbAddr,
    input  dataT slbData,
    input  lenT  slbLen,
    input  nickT slbNick,
    output logic slbFree,
    output logic slbDone,
    output dataT slbResult,
    output nickT slbDoneNick,

    input  logic fetchEn,
    input  addrT fetchAddr,
    output logic fetchBusy,
    output logic fetchDone,
    output dataT fetchInst
);

    memWaitT memWait;
    logic    dataReq;
    logic    dataStore;
    addrT    dataAddr;
    dataT    dataWdata;
    lenT     dataLen;
    logic    dataDone;
    dataT    dataRdata;
    logic    instReq;
    addrT    instAddr;
    logic    instDone;
    dataT    instRdata;
    ramAddrT ramAddr;
    logic    ramWe;
    byteT    ramWdata;
    byteT    ramRdata;

    dataPort u_dataPort (
        .clk(clk), .rst(rst), .rdy(rdy),
        .slbEn(slbEn), .slbStore(slbStore), .slbAddr(slbAddr),
        .slbData(slbData), .slbLen(slbLen), .slbNick(slbNick),
        .slbFree(slbFree), .slbDone(slbDone), .slbResult(slbResult),
        .slbDoneNick(slbDoneNick),
        .memWait(memWait), .dataDone(dataDone), .dataRdata(dataRdata),
        .dataReq(dataReq), .dataStore(dataStore), .dataAddr(dataAddr),
        .dataWdata(dataWdata), .dataLen(dataLen)
    );

    fetchPort u_fetchPort (
        .clk(clk), .rst(rst), .rdy(rdy),
        .fetchEn(fetchEn), .fetchAddr(fetchAddr),
        .fetchBusy(fetchBusy), .fetchDone(fetchDone), .fetchInst(fetchInst),
        .memWait(memWait), .instDone(instDone), .instRdata(instRdata),
        .instReq(instReq), .instAddr(instAddr)
    );

    memCtrl u_memCtrl (
        .clk(clk), .rst(rst), .rdy(rdy),
        .dataReq(dataReq), .dataStore(dataStore), .dataAddr(dataAddr),
        .dataWdata(dataWdata), .dataLen(dataLen),
        .dataDone(dataDone), .dataRdata(dataRdata),
        .instReq(instReq), .instAddr(instAddr),
        .instDone(instDone), .instRdata(instRdata),
        .memWait(memWait),
        .ramAddr(ramAddr), .ramWe(ramWe), .ramWdata(ramWdata),
        .ramRdata(ramRdata)
    );

    byteRam u_byteRam (
        .clk(clk),
        .ramAddr(ramAddr), .ramWe(ramWe), .ramWdata(ramWdata),
        .ramRdata(ramRdata)
    );

endmodule

// File: hw/mem_defs.svh
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// Bus widths.
`define ADDR_WIDTH 32
`define DATA_WIDTH 32
`define BYTE_WIDTH 8

// Tag of a store/load buffer entry.
`define NICK_WIDTH 4

// Byte count of one access, legal values 1, 2 and 4.
`define LEN_WIDTH 3

// Busy vector from the memory controller.
`define WAIT_WIDTH 2

// Used address bits, 4 KiB of RAM.
`define RAM_ADDR_WIDTH 12

// Instruction cache index bits, 16 lines.
`define ICACHE_INDEX_WIDTH 4

`endif

// File: testbench/tbMemSubsystem.sv
`timescale 1ns/1ps
`include "mem_defs.svh"

module tbMemSubsystem import memPkg::*; ();

    localparam int RAM_SIZE = 1 << `RAM_ADDR_WIDTH;
    localparam int TIMEOUT  = 200;

    typedef struct packed {
        logic isStore;
        nickT nick;
        dataT value;
    } dataExpT;

    logic clk;
    logic rst;
    logic rdy;
    logic slbEn;
    logic slbStore;
    addrT slbAddr;
    dataT slbData;
    lenT  slbLen;
    nickT slbNick;
    logic slbFree;
    logic slbDone;
    dataT slbResult;
    nickT slbDoneNick;
    logic fetchEn;
    addrT fetchAddr;
    logic fetchBusy;
    logic fetchDone;
    dataT fetchInst;

    byteT        model [RAM_SIZE];
    logic [31:0] lfsr;
    logic        stallOn;
    dataExpT     dataExp [$];
    dataT        fetchExp [$];
    int          dataDoneCount;
    int          fetchDoneCount;
    logic        dataPending;
    logic        fetchPending;

    memSubsystem u_dut (
        .clk(clk), .rst(rst), .rdy(rdy),
        .slbEn(slbEn), .slbStore(slbStore), .slbAddr(slbAddr),
        .slbData(slbData), .slbLen(slbLen), .slbNick(slbNick),
        .slbFree(slbFree), .slbDone(slbDone), .slbResult(slbResult),
        .slbDoneNick(slbDoneNick),
        .fetchEn(fetchEn), .fetchAddr(fetchAddr),
        .fetchBusy(fetchBusy), .fetchDone(fetchDone), .fetchInst(fetchInst)
    );

    initial begin
        clk = 1'b0;
    end

    always #50 clk = ~clk;

    // Taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrNext(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic lenT randLen();
        logic [1:0] pick;
        pick = 2'(randBits(2));
        return (pick == 2'd0) ? lenT'(1) : (pick == 2'd1) ? lenT'(2) : lenT'(4);
    endfunction

    // Little-endian bytes, upper bytes zero.
    function automatic dataT expectedLoad(input addrT addr, input lenT len);
        dataT v;
        v = '0;
        for (int i = 0; i < len; i++) begin
            v[8*i +: 8] = model[ramAddrT'(addr + addrT'(i))];
        end
        return v;
    endfunction

    function automatic dataT expectedInst(input addrT addr);
        return expectedLoad({addr[31:2], 2'b00}, lenT'(4));
    endfunction

    task automatic stopWithFail();
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic reportFailure(input string what);
        $display("ERROR at %0t: %s", $time, what);
        stopWithFail();
    endtask

    task automatic reportMismatch(input string name, input dataT got, input dataT exp);
        $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
        stopWithFail();
    endtask

    task automatic checkValue(input string name, input dataT got, input dataT exp);
        assert (got === exp) else reportMismatch(name, got, exp);
    endtask

    task automatic driveRdy();
        if (stallOn) begin
            rdy = (randBits(2) != 32'd0);
        end else begin
            rdy = 1'b1;
        end
    endtask

    // Called at a falling edge; the model takes store bytes right away.
    task automatic putData(input logic store, input addrT addr, input dataT data,
                           input lenT len);
        dataExpT item;
        rdy      = 1'b1;
        slbEn    = 1'b1;
        slbStore = store;
        slbAddr  = addr;
        slbData  = data;
        slbLen   = len;
        slbNick  = nickT'(randBits(4));
        item.isStore = store;
        item.nick    = slbNick;
        item.value   = store ? '0 : expectedLoad(addr, len);
        dataExp.push_back(item);
        if (store) begin
            for (int i = 0; i < len; i++) begin
                model[ramAddrT'(addr + addrT'(i))] = data[8*i +: 8];
            end
        end
    endtask

    task automatic putFetch(input addrT addr);
        rdy       = 1'b1;
        fetchEn   = 1'b1;
        fetchAddr = addr;
        fetchExp.push_back(expectedInst(addr));
    endtask

    task automatic waitDone(input int dataTarget, input int fetchTarget);
        int cycles;
        cycles = 0;
        while (dataDoneCount < dataTarget || fetchDoneCount < fetchTarget) begin
            @(negedge clk);
            slbEn   = 1'b0;
            fetchEn = 1'b0;
            driveRdy();
            cycles++;
            if (cycles > TIMEOUT) begin
                reportFailure("timed out waiting for a done pulse");
            end
        end
    endtask

    task automatic storeThenLoad(input addrT addr);
        @(negedge clk);
        putData(1'b1, addr, randBits(32), randLen());
        waitDone(dataDoneCount + 1, fetchDoneCount);
        @(negedge clk);
        putData(1'b0, addr, '0, randLen());
        waitDone(dataDoneCount + 1, fetchDoneCount);
    endtask

    task automatic fetchOnce(input addrT addr);
        @(negedge clk);
        putFetch(addr);
        waitDone(dataDoneCount, fetchDoneCount + 1);
    endtask

    // Line is known to miss, so the port stays busy through the refill.
    task automatic fetchMiss(input addrT addr);
        int target;
        @(negedge clk);
        putFetch(addr);
        target = fetchDoneCount + 1;
        @(negedge clk);
        fetchEn = 1'b0;
        checkValue("fetchBusy", dataT'(fetchBusy), 32'd1);
        waitDone(dataDoneCount, target);
    endtask

    // Line is known to be valid, so the answer comes one cycle later.
    task automatic fetchHit(input addrT addr);
        int target;
        @(negedge clk);
        putFetch(addr);
        target = fetchDoneCount + 1;
        @(negedge clk);
        fetchEn = 1'b0;
        assert (fetchDone) else reportFailure("cache hit did not answer in the next cycle");
        waitDone(dataDoneCount, target);
    endtask

    always @(posedge clk) begin : compare
        dataExpT item;
        dataT    expInst;
        if (!rst) begin
            assert (rdy || !(slbDone || fetchDone))
                else reportFailure("done pulse seen while rdy was low");
            if (slbDone) begin
                assert (dataPending && dataExp.size() != 0)
                    else reportFailure("slbDone without a pending request");
                item = dataExp.pop_front();
                if (!item.isStore) begin
                    checkValue("slbResult", slbResult, item.value);
                end
                checkValue("slbDoneNick", dataT'(slbDoneNick), dataT'(item.nick));
                dataPending = 1'b0;
                dataDoneCount++;
            end else if (dataPending) begin
                assert (!slbFree) else reportFailure("slbFree rose before slbDone");
            end
            if (slbEn) begin
                assert (slbFree) else reportFailure("request given while slbFree was low");
                dataPending = 1'b1;
            end
            if (fetchDone) begin
                assert (fetchPending && fetchExp.size() != 0)
                    else reportFailure("fetchDone without a pending fetch");
                expInst = fetchExp.pop_front();
                checkValue("fetchInst", fetchInst, expInst);
                fetchPending = 1'b0;
                fetchDoneCount++;
            end
            if (fetchEn) begin
                assert (rdy && !fetchBusy)
                    else reportFailure("fetch given while the port was busy");
                fetchPending = 1'b1;
            end
        end
    end

    initial begin : stimulus
        logic [1:0] pick;
        lfsr           = 32'h17430849;
        stallOn        = 1'b0;
        dataDoneCount  = 0;
        fetchDoneCount = 0;
        dataPending    = 1'b0;
        fetchPending   = 1'b0;
        rst       = 1'b1;
        rdy       = 1'b1;
        slbEn     = 1'b0;
        slbStore  = 1'b0;
        slbAddr   = '0;
        slbData   = '0;
        slbLen    = lenT'(1);
        slbNick   = '0;
        fetchEn   = 1'b0;
        fetchAddr = '0;
        for (int i = 0; i < RAM_SIZE; i++) begin
            model[i] = '0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        @(negedge clk);
        checkValue("slbFree", dataT'(slbFree), 32'd1);
        checkValue("slbDone", dataT'(slbDone), 32'd0);
        checkValue("fetchDone", dataT'(fetchDone), 32'd0);
        checkValue("fetchBusy", dataT'(fetchBusy), 32'd0);
        putData(1'b0, addrT'(32'hA40), '0, lenT'(4));
        waitDone(1, 0);

        // Data lives in a small window of the upper half to force overlaps.
        for (int n = 0; n < 40; n++) begin
            storeThenLoad(addrT'(32'h800 + randBits(8)));
        end

        // Code words in the lower half.
        for (int n = 0; n < 24; n++) begin
            @(negedge clk);
            putData(1'b1, addrT'(4 * n), randBits(32), lenT'(4));
            waitDone(dataDoneCount + 1, fetchDoneCount);
        end
        for (int n = 0; n < 8; n++) begin
            @(negedge clk);
            putData(1'b1, addrT'(32'h100 + 4 * n), randBits(32), lenT'(4));
            waitDone(dataDoneCount + 1, fetchDoneCount);
        end
        for (int n = 0; n < 24; n++) begin
            fetchMiss(addrT'(4 * n));
            fetchHit(addrT'(4 * n + randBits(2)));
        end

        // Load and refill start in the same cycle.
        for (int n = 0; n < 8; n++) begin
            @(negedge clk);
            putData(1'b0, addrT'(32'h800 + randBits(8)), '0, randLen());
            putFetch(addrT'(32'h100 + 4 * n));
            waitDone(dataDoneCount + 1, fetchDoneCount + 1);
        end

        stallOn = 1'b1;
        for (int n = 0; n < 40; n++) begin
            pick = 2'(randBits(2));
            if (pick == 2'd0) begin
                fetchOnce(addrT'(4 * randBits(4)));
            end else if (pick == 2'd1) begin
                @(negedge clk);
                putData(1'b0, addrT'(32'h800 + randBits(8)), '0, randLen());
                putFetch(addrT'(4 * randBits(4)));
                waitDone(dataDoneCount + 1, fetchDoneCount + 1);
            end else begin
                storeThenLoad(addrT'(32'h800 + randBits(8)));
            end
        end
        stallOn = 1'b0;
        @(negedge clk);
        rdy = 1'b1;

        $display("=== PASS ===");
        $finish;
    end

endmodule
